// File: logic/ibuf_pkg.sv
package ibuf_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int num_warps = 8;
    localparam int ib_depth  = 4;                   // entries per warp
    localparam int ptr_w     = 3;                   // index bits plus wrap bit
    localparam int warp_id_w = $clog2(num_warps);
    localparam int reg_id_w  = 5;

    typedef logic [warp_id_w-1:0] warp_id_t;
    typedef logic [num_warps-1:0] warp_vec_t;      // one bit per warp

    // register operand, valid bit on top
    typedef struct packed {
        logic                valid;
        logic [reg_id_w-1:0] id;
    } reg_ref_t;

    //////////////////////////////////////////////////////////////////////
    // decoded instruction as written by the decode stage
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] instr;             // raw instruction word
        reg_ref_t    src1;
        reg_ref_t    src2;
        reg_ref_t    dst;
        logic [3:0]  alu_op;
        logic [15:0] imm;
        logic        regwrite;
        logic        memwrite;
        logic        memread;
        logic        shared_global;     // shared when set, global otherwise
        logic        beq;
        logic        blt;
        logic        exit;              // warp terminates at this instruction
    } dec_instr_t;

endpackage

// File: logic/ibuf_warp.sv
`timescale 1ns/1ps

module ibuf_warp
    import ibuf_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // decode side
    input  logic       wr_en,
    input  dec_instr_t wr_instr,
    // fetch side
    input  logic       fetch_valid,
    output logic       fetch_req,
    // scoreboard state for this warp
    input  logic       scb_stall,
    input  logic       scb_empty,
    // issue unit handshake
    output logic       issue_req,
    input  logic       issue_grant,
    output logic       exit_req,
    input  logic       exit_grant,
    // head entry towards the select
    output dec_instr_t head
);

    //////////////////////////////////////////////////////////////////////
    // queue storage and pointers
    //////////////////////////////////////////////////////////////////////

    dec_instr_t       mem [ib_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] occupancy;
    logic [ptr_w-1:0] credit_sum;
    logic             head_valid;
    logic             full;
    logic             push;
    logic             pop;

    // wrap bit makes full and empty distinct
    assign occupancy  = wr_ptr - rd_ptr;
    assign head_valid = (occupancy != '0);
    assign full       = (occupancy == ptr_w'(ib_depth));

    // a write into a full queue is ignored so the pointers stay sane
    assign push = wr_en & ~full;
    assign pop  = head_valid & (issue_grant | exit_grant);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // entry payload written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[ptr_w-2:0]] <= wr_instr;
        end
    end

    assign head = mem[rd_ptr[ptr_w-2:0]];

    //////////////////////////////////////////////////////////////////////
    // fetch credit
    //////////////////////////////////////////////////////////////////////

    // count what is stored, what is in flight upstream and what lands now
    // pops are left out so the credit never depends on a grant
    assign credit_sum = occupancy + ptr_w'(fetch_valid) + ptr_w'(wr_en);
    assign fetch_req  = (credit_sum < ptr_w'(ib_depth));

    //////////////////////////////////////////////////////////////////////
    // issue and exit requests
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        issue_req = 1'b0;
        exit_req  = 1'b0;
        if (head_valid) begin
            if (head.exit) begin
                exit_req = scb_empty;       // wait for all writes to retire
            end else begin
                issue_req = ~scb_stall;     // full or dependent
            end
        end
    end

endmodule

// File: logic/issue_select.sv
`timescale 1ns/1ps

module issue_select
    import ibuf_pkg::*;
(
    // one-hot or zero grants from the issue unit
    input  warp_vec_t  issue_grant,
    input  warp_vec_t  exit_grant,
    // current head of every warp queue
    input  dec_instr_t heads [num_warps],
    // towards the operand collector
    output logic       issue_valid,
    output warp_id_t   issue_warp,
    output dec_instr_t issue_instr,
    // towards the register allocation unit
    output logic       exit_valid,
    output warp_id_t   exit_warp
);

    // one-hot to index, zero when nothing is granted
    function automatic warp_id_t grant_to_id(input warp_vec_t grant);
        warp_id_t id;
        id = '0;
        for (int i = 0; i < num_warps; i++) begin
            if (grant[i]) begin
                id = warp_id_t'(i);
            end
        end
        return id;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // issue path
    //////////////////////////////////////////////////////////////////////

    assign issue_valid = |issue_grant;
    assign issue_warp  = grant_to_id(issue_grant);

    // falls back to warp 0 when idle, qualified by issue_valid
    assign issue_instr = heads[issue_warp];

    //////////////////////////////////////////////////////////////////////
    // exit path
    //////////////////////////////////////////////////////////////////////

    assign exit_valid = |exit_grant;
    assign exit_warp  = grant_to_id(exit_grant);

endmodule

// File: logic/ibuf_top.sv
`timescale 1ns/1ps

module ibuf_top
    import ibuf_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // decode stage
    input  logic       dec_valid,
    input  warp_id_t   dec_warp,
    input  dec_instr_t dec_instr,
    input  logic       drop,            // from the SIMT stack
    // fetch stage
    input  warp_vec_t  fetch_valid,
    output warp_vec_t  fetch_req,
    // scoreboard
    input  warp_vec_t  scb_stall,
    input  warp_vec_t  scb_empty,
    // issue unit
    output warp_vec_t  issue_req,
    input  warp_vec_t  issue_grant,
    output warp_vec_t  exit_req,
    input  warp_vec_t  exit_grant,
    // operand collector
    output logic       issue_valid,
    output warp_id_t   issue_warp,
    output dec_instr_t issue_instr,
    // register allocation unit
    output logic       exit_valid,
    output warp_id_t   exit_warp
);

    warp_vec_t  wr_en;
    dec_instr_t heads [num_warps];

    //////////////////////////////////////////////////////////////////////
    // decode write demux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        wr_en           = '0;
        wr_en[dec_warp] = dec_valid & ~drop;    // dropped slots vanish here
    end

    //////////////////////////////////////////////////////////////////////
    // per-warp queues
    //////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < num_warps; w++) begin : g_warp
        ibuf_warp u_warp (
            .clk         (clk),
            .rst         (rst),
            .wr_en       (wr_en[w]),
            .wr_instr    (dec_instr),       // shared bus, enable picks the warp
            .fetch_valid (fetch_valid[w]),
            .fetch_req   (fetch_req[w]),
            .scb_stall   (scb_stall[w]),
            .scb_empty   (scb_empty[w]),
            .issue_req   (issue_req[w]),
            .issue_grant (issue_grant[w]),
            .exit_req    (exit_req[w]),
            .exit_grant  (exit_grant[w]),
            .head        (heads[w])
        );
    end

    // output mux and warp id encoding
    issue_select u_select (
        .issue_grant (issue_grant),
        .exit_grant  (exit_grant),
        .heads       (heads),
        .issue_valid (issue_valid),
        .issue_warp  (issue_warp),
        .issue_instr (issue_instr),
        .exit_valid  (exit_valid),
        .exit_warp   (exit_warp)
    );

endmodule

// File: sim/ibuf_checker.sv
`timescale 1ns/1ps

module ibuf_checker
    import ibuf_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input warp_vec_t wr_en,
    input warp_vec_t issue_req,
    input warp_vec_t exit_req,
    input warp_vec_t issue_grant,
    input warp_vec_t exit_grant,
    input logic      issue_valid,
    input warp_id_t  issue_warp
);

    logic [ptr_w-1:0] occ [num_warps];      // shadow fill level per warp
    warp_vec_t        full;

    always_comb begin
        for (int w = 0; w < num_warps; w++) begin
            full[w] = (occ[w] == ptr_w'(ib_depth));
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < num_warps; w++) begin
                occ[w] <= '0;
            end
        end else begin
            for (int w = 0; w < num_warps; w++) begin
                occ[w] <= occ[w] + ptr_w'(wr_en[w] & ~full[w])
                        - ptr_w'((occ[w] != '0) & (issue_grant[w] | exit_grant[w]));
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // handshake rules
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rst) issue_valid |-> issue_req[issue_warp])
        else $error("issue granted to a warp without a request");
    assert property (@(posedge clk) disable iff (!rst) (exit_grant & ~exit_req) == '0)
        else $error("exit granted to a warp without a request");
    assert property (@(posedge clk) disable iff (!rst) (wr_en & full) == '0)
        else $error("write into a full warp queue");
    assert property (@(posedge clk) disable iff (!rst)
                     $onehot0(issue_grant) && $onehot0(exit_grant))
        else $error("more than one warp granted at once");

endmodule

bind ibuf_top ibuf_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .wr_en       (wr_en),
    .issue_req   (issue_req),
    .exit_req    (exit_req),
    .issue_grant (issue_grant),
    .exit_grant  (exit_grant),
    .issue_valid (issue_valid),
    .issue_warp  (issue_warp)
);

// File: sim/ibuf_tb.sv
`timescale 1ns/1ps

module ibuf_tb
    import ibuf_pkg::*;
();

    localparam logic [31:0] seed        = 32'hf94d_7166;
    localparam int          drain_limit = 200;     // cycles per drain wait
    localparam int          rand_cycles = 400;

    logic       clk = 1'b0;
    logic       rst;
    logic       dec_valid;
    warp_id_t   dec_warp;
    dec_instr_t dec_instr;
    logic       drop;
    warp_vec_t  fetch_valid;
    warp_vec_t  fetch_req;
    warp_vec_t  scb_stall;
    warp_vec_t  scb_empty;
    warp_vec_t  issue_req;
    warp_vec_t  issue_grant;
    warp_vec_t  exit_req;
    warp_vec_t  exit_grant;
    logic       issue_valid;
    warp_id_t   issue_warp;
    dec_instr_t issue_instr;
    logic       exit_valid;
    warp_id_t   exit_warp;

    logic [31:0] lfsr = seed;
    dec_instr_t  model_q [num_warps][$];            // expected contents per warp
    dec_instr_t  last_issue [num_warps];
    warp_id_t    last_exit;
    int          exits  = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests  = 0;

    always #50 clk = ~clk;

    ibuf_top dut (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_warp    (dec_warp),
        .dec_instr   (dec_instr),
        .drop        (drop),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req),
        .scb_stall   (scb_stall),
        .scb_empty   (scb_empty),
        .issue_req   (issue_req),
        .issue_grant (issue_grant),
        .exit_req    (exit_req),
        .exit_grant  (exit_grant),
        .issue_valid (issue_valid),
        .issue_warp  (issue_warp),
        .issue_instr (issue_instr),
        .exit_valid  (exit_valid),
        .exit_warp   (exit_warp)
    );

    //////////////////////////////////////////////////////////////////////
    // random source and helpers
    //////////////////////////////////////////////////////////////////////

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic dec_instr_t rand_instr(input bit is_exit);
        dec_instr_t  d;
        logic [31:0] a;
        logic [31:0] b;
        logic [12:0] c;
        a      = rand_bits(32);
        b      = rand_bits(32);
        c      = 13'(rand_bits(13));
        d      = {a, b, c};
        d.exit = is_exit;
        return d;
    endfunction

    function automatic bit pending(input warp_vec_t mask);
        bit busy;
        busy = 1'b0;
        for (int i = 0; i < num_warps; i++) begin
            if (mask[i] && model_q[i].size() != 0) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    task automatic check(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("mismatch at time %0t: %s", $time, what);
            errors++;
        end
    endtask

    // issue unit model, one random warp among the requesters
    task automatic pick_one(input warp_vec_t req, output warp_vec_t g, output warp_id_t id);
        int cnt;
        int k;
        cnt = $countones(req);
        g   = '0;
        id  = '0;
        if (cnt != 0) begin
            k = int'(rand_bits(3)) % cnt;
            for (int i = 0; i < num_warps; i++) begin
                if (req[i]) begin
                    if (k == 0) begin
                        g[i] = 1'b1;
                        id   = warp_id_t'(i);
                    end
                    k--;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one clock cycle against the model
    //////////////////////////////////////////////////////////////////////

    task automatic step(input bit enq, input warp_id_t w, input bit drop_in,
                        input dec_instr_t ins, input warp_vec_t stall,
                        input warp_vec_t empty, input bit grant_on);
        warp_vec_t exp_issue;
        warp_vec_t exp_exit;
        warp_vec_t exp_fetch;
        warp_vec_t ig;
        warp_vec_t eg;
        warp_id_t  gi;
        warp_id_t  ge;
        bit        push;
        int        occ;
        push = enq && !drop_in;
        for (int i = 0; i < num_warps; i++) begin
            occ          = model_q[i].size();
            exp_issue[i] = 1'b0;
            exp_exit[i]  = 1'b0;
            if (occ > 0) begin
                exp_issue[i] = !model_q[i][0].exit && !stall[i];
                exp_exit[i]  = model_q[i][0].exit && empty[i];
            end
            // credit counts stored entries plus the one landing now
            exp_fetch[i] = (occ + int'(push && w == warp_id_t'(i))) < ib_depth;
        end
        ig = '0;
        eg = '0;
        gi = '0;
        ge = '0;
        if (grant_on) begin
            pick_one(exp_issue, ig, gi);
            pick_one(exp_exit, eg, ge);
        end
        @(negedge clk);
        dec_valid   = enq;
        dec_warp    = w;
        dec_instr   = ins;
        drop        = drop_in;
        fetch_valid = '0;
        scb_stall   = stall;
        scb_empty   = empty;
        issue_grant = ig;
        exit_grant  = eg;
        #10;
        check(fetch_req == exp_fetch,
              $sformatf("fetch_req %b, expected %b", fetch_req, exp_fetch));
        check(issue_req == exp_issue,
              $sformatf("issue_req %b, expected %b", issue_req, exp_issue));
        check(exit_req == exp_exit,
              $sformatf("exit_req %b, expected %b", exit_req, exp_exit));
        check(issue_valid == (ig != '0), "issue_valid does not follow the grant");
        if (ig != '0) begin
            check(issue_warp == gi, $sformatf("issue_warp %0d, expected %0d", issue_warp, gi));
            check(issue_instr == model_q[gi][0], $sformatf("warp %0d issued out of order", gi));
            last_issue[gi] = issue_instr;
            void'(model_q[gi].pop_front());
        end
        check(exit_valid == (eg != '0), "exit_valid does not follow the exit grant");
        if (eg != '0) begin
            check(exit_warp == ge, $sformatf("exit_warp %0d, expected %0d", exit_warp, ge));
            void'(model_q[ge].pop_front());
        end
        if (exit_valid) begin
            last_exit = exit_warp;
            exits++;
        end
        if (push) begin
            model_q[w].push_back(ins);
        end
    endtask

    // grant freely until the masked queues are empty
    task automatic drain(input warp_vec_t mask);
        int n;
        n = 0;
        while (pending(mask) && n < drain_limit) begin
            step(1'b0, '0, 1'b0, '0, '0, '1, 1'b1);
            n++;
        end
        if (pending(mask)) begin
            $display("timeout: queues %b still hold instructions after %0d cycles",
                     mask, drain_limit);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("test %-6s done, %0d errors", name, errors - errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int         e;
        int         exits_before;
        dec_instr_t ins_a;
        dec_instr_t ins_b;
        warp_id_t   w;
        bit         enq;
        bit         drp;
        bit         ex;
        warp_vec_t  stall;
        warp_vec_t  empty;
        rst         = 1'b0;
        dec_valid   = 1'b0;
        dec_warp    = '0;
        dec_instr   = '0;
        drop        = 1'b0;
        fetch_valid = '0;
        scb_stall   = '0;
        scb_empty   = '0;
        issue_grant = '0;
        exit_grant  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        e = errors;
        #10;
        check(issue_req == '0, "issue_req not idle after reset");
        check(exit_req == '0, "exit_req not idle after reset");
        check(!issue_valid && !exit_valid, "issue or exit valid after reset");
        check(fetch_req == '1, "fetch credit missing after reset");
        finish_test("reset", e);

        e = errors;
        for (int i = 0; i < ib_depth; i++) begin
            step(1'b1, 3'd2, 1'b0, rand_instr(1'b0), '0, '1, 1'b0);
        end
        step(1'b0, '0, 1'b0, '0, '0, '1, 1'b0);    // held, nothing granted
        check(fetch_req[2] == 1'b0, "full warp 2 still offers fetch credit");
        drain('1);
        finish_test("fill", e);

        e     = errors;
        ins_a = rand_instr(1'b0);
        ins_b = rand_instr(1'b0);
        step(1'b1, 3'd5, 1'b1, ins_a, '0, '1, 1'b0);
        step(1'b1, 3'd5, 1'b0, ins_b, '0, '1, 1'b0);
        drain('1);
        check(last_issue[5] == ins_b, "warp 5 did not issue the instruction after the drop");
        finish_test("drop", e);

        e = errors;
        step(1'b1, 3'd6, 1'b0, rand_instr(1'b0), 8'h40, '1, 1'b1);
        repeat (3) step(1'b0, '0, 1'b0, '0, 8'h40, '1, 1'b1);
        step(1'b0, '0, 1'b0, '0, '0, '1, 1'b0);    // stall released
        check(issue_req[6] == 1'b1, "warp 6 does not request after its stall cleared");
        drain('1);
        finish_test("stall", e);

        e            = errors;
        exits_before = exits;
        step(1'b1, 3'd3, 1'b0, rand_instr(1'b1), '0, '0, 1'b1);
        repeat (3) step(1'b0, '0, 1'b0, '0, '0, '0, 1'b1);   // scoreboard busy
        check(exit_req[3] == 1'b0, "warp 3 requests exit while its scoreboard is busy");
        drain(8'h08);
        check(last_exit == 3'd3 && exits == exits_before + 1, "exit grant of warp 3 not seen");
        finish_test("exit", e);

        e = errors;
        for (int i = 0; i < rand_cycles; i++) begin
            w     = warp_id_t'(rand_bits(3));
            enq   = rand_bits(1) == 32'd1 && model_q[w].size() < ib_depth;
            drp   = rand_bits(3) == 32'd0;
            ex    = rand_bits(3) == 32'd0;
            stall = warp_vec_t'(rand_bits(8) & rand_bits(8));
            empty = warp_vec_t'(rand_bits(8) | rand_bits(8));
            step(enq, w, drp, rand_instr(ex), stall, empty, 1'b1);
        end
        drain('1);
        finish_test("random", e);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/ibuf_pkg.sv
logic/ibuf_warp.sv
logic/issue_select.sv
logic/ibuf_top.sv
sim/ibuf_checker.sv
sim/ibuf_tb.sv

// File: run.sh
#!/bin/sh
# build and run the instruction buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ibuf_tb \
    -f vlog.f --Mdir obj_dir -o ibuf_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/ibuf_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
